// File: source/noc_router_cfg.svh
`ifndef NOC_ROUTER_CFG_SVH
`define NOC_ROUTER_CFG_SVH

// flit payload width.
`define NOC_PAYLOAD_BITS 32

// width of one mesh coordinate, x or y.
`define NOC_COORD_BITS 4

// words per input buffer, head register included.
`define NOC_BUF_DEPTH 8

// buffered word count at which almost-full rises.
`define NOC_BUF_THRESHOLD 6

`endif

// File: source/noc_pkg.sv
`include "noc_router_cfg.svh"

package noc_pkg;

  typedef enum logic [1:0] {
    HEAD   = 2'd0,
    BODY   = 2'd1,
    TAIL   = 2'd2,
    SINGLE = 2'd3  // head and tail in one flit.
  } flit_kind_e;

  // in a head or single flit the payload starts with dest_x, then dest_y.
  typedef struct packed {
    flit_kind_e                   kind;
    logic [`NOC_PAYLOAD_BITS-1:0] payload;
  } flit_t;

  // south and west are never reached in this quadrant.
  typedef enum logic [1:0] {
    PORT_EAST  = 2'd0,
    PORT_NORTH = 2'd1,
    PORT_LOCAL = 2'd2
  } out_port_e;

endpackage

// File: source/noc_flit_if.sv
`timescale 1ns/1ps
`include "noc_router_cfg.svh"

interface noc_flit_if
  import noc_pkg::*;
();
  logic      valid;
  logic      ready;
  flit_t     flit;
  out_port_e port;   // held route for body and tail flits.

  modport sender (
    output valid,
    output flit,
    output port,
    input  ready
  );

  modport receiver (
    input  valid,
    input  flit,
    input  port,
    output ready
  );
endinterface

// File: source/noc_fifo_mem.sv
`timescale 1ns/1ps
`include "noc_router_cfg.svh"

module noc_fifo_mem #(
  parameter int WIDTH     = `NOC_PAYLOAD_BITS,
  parameter int DEPTH     = `NOC_BUF_DEPTH,
  parameter int THRESHOLD = `NOC_BUF_THRESHOLD
)(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_clear,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_pop,
  output logic             o_empty,
  output logic             o_almost_full,
  output logic             o_full,
  output logic [WIDTH-1:0] o_data
);
  localparam int                  CNT_BITS = $clog2(DEPTH + 1);
  localparam int                  PTR_BITS = $clog2(DEPTH - 1);
  localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(DEPTH - 2);
  localparam logic [CNT_BITS-1:0] CNT_FULL = CNT_BITS'(DEPTH);
  localparam logic [CNT_BITS-1:0] CNT_AF   = CNT_BITS'(THRESHOLD);

  logic                push;
  logic                pop;
  logic                empty_q;
  logic                full_q;
  logic                afull_q;
  logic [CNT_BITS-1:0] count_q;
  logic [CNT_BITS-1:0] count_nxt;
  logic                to_head;
  logic                to_mem;
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [WIDTH-1:0]    mem [DEPTH-1];
  logic [WIDTH-1:0]    head_q;

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
  endfunction

  assign push = i_push && !full_q;   // writes into a full buffer are dropped.
  assign pop  = i_pop && !empty_q;

  always_comb begin
    case ({push, pop})
      2'b10:   count_nxt = count_q + 1'b1;
      2'b01:   count_nxt = count_q - 1'b1;
      default: count_nxt = count_q;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      empty_q <= 1'b1;
      full_q  <= 1'b0;
    end
    else if (i_clear) begin
      count_q <= '0;
      empty_q <= 1'b1;
      full_q  <= 1'b0;
    end
    else if (push || pop) begin
      count_q <= count_nxt;
      empty_q <= (count_nxt == '0);
      full_q  <= (count_nxt == CNT_FULL);
    end
  end

  if (THRESHOLD < DEPTH) begin : g_afull
    always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
        afull_q <= 1'b0;
      end
      else if (i_clear) begin
        afull_q <= 1'b0;
      end
      else if (push || pop) begin
        afull_q <= (count_nxt >= CNT_AF);
      end
    end
  end
  else begin : g_afull_is_full
    assign afull_q = full_q;
  end

  // the head register takes the word directly when nothing sits behind it.
  assign to_head = empty_q || ((count_q == 1) && pop);
  assign to_mem  = !to_head;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else if (i_clear) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else begin
      if (push && to_mem) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop && (count_q >= 2)) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);   // memory word moves up into the head.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push && to_mem) begin
      mem[wr_ptr_q] <= i_data;
    end
  end

  always_ff @(posedge clk) begin
    if (push && to_head) begin
      head_q <= i_data;
    end
    else if (pop) begin
      head_q <= mem[rd_ptr_q];
    end
  end

  assign o_empty       = empty_q;
  assign o_full        = full_q;
  assign o_almost_full = afull_q;
  assign o_data        = head_q;
endmodule

// File: source/noc_input_unit.sv
`timescale 1ns/1ps
`include "noc_router_cfg.svh"

module noc_input_unit
  import noc_pkg::*;
#(
  parameter logic [`NOC_COORD_BITS-1:0] MY_X = '0,
  parameter logic [`NOC_COORD_BITS-1:0] MY_Y = '0
)(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_clear,
  input  logic       i_valid,
  output logic       o_ready,
  input  flit_t      i_flit,
  output logic       o_almost_full,
  noc_flit_if.sender o_out
);
  logic                       empty;
  logic                       full;
  logic                       pop;
  logic [$bits(flit_t)-1:0]   buf_word;
  flit_t                      head;
  logic [`NOC_COORD_BITS-1:0] dest_x;
  logic [`NOC_COORD_BITS-1:0] dest_y;
  out_port_e                  route;
  out_port_e                  held_port_q;
  logic                       in_pkt_q;

  noc_fifo_mem #(
    .WIDTH     ($bits(flit_t)),
    .DEPTH     (`NOC_BUF_DEPTH),
    .THRESHOLD (`NOC_BUF_THRESHOLD)
  ) u_buf (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_clear       (i_clear),
    .i_push        (i_valid),
    .i_data        (i_flit),
    .i_pop         (pop),
    .o_empty       (empty),
    .o_almost_full (o_almost_full),
    .o_full        (full),
    .o_data        (buf_word)
  );

  assign o_ready = !full;
  assign head    = flit_t'(buf_word);
  assign pop     = o_out.valid && o_out.ready;
  assign dest_x  = head.payload[`NOC_COORD_BITS-1:0];
  assign dest_y  = head.payload[2*`NOC_COORD_BITS-1:`NOC_COORD_BITS];

  // xy routing, x first.
  always_comb begin
    if (dest_x > MY_X) begin
      route = PORT_EAST;
    end
    else if (dest_y > MY_Y) begin
      route = PORT_NORTH;
    end
    else begin
      route = PORT_LOCAL;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      in_pkt_q    <= 1'b0;
      held_port_q <= PORT_LOCAL;
    end
    else if (i_clear) begin
      in_pkt_q <= 1'b0;
    end
    else if (pop) begin
      if (head.kind == HEAD) begin
        in_pkt_q    <= 1'b1;
        held_port_q <= route;
      end
      else if (head.kind == TAIL) begin
        in_pkt_q <= 1'b0;
      end
    end
  end

  assign o_out.valid = !empty;
  assign o_out.flit  = head;
  assign o_out.port  = in_pkt_q ? held_port_q : route;   // body payload is not a route.
endmodule

// File: source/noc_switch.sv
`timescale 1ns/1ps
`include "noc_router_cfg.svh"

module noc_switch
  import noc_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         i_clear,
  noc_flit_if.receiver i_in_w,
  noc_flit_if.receiver i_in_l,
  output logic         o_e_valid,
  input  logic         i_e_ready,
  output flit_t        o_e_flit,
  output logic         o_n_valid,
  input  logic         i_n_ready,
  output flit_t        o_n_flit,
  output logic         o_l_valid,
  input  logic         i_l_ready,
  output flit_t        o_l_flit
);
  localparam int N_IN  = 2;
  localparam int N_OUT = 3;

  logic      [N_IN-1:0]  in_valid;
  logic      [N_IN-1:0]  in_ready;
  flit_t                 in_flit [N_IN];
  out_port_e             in_port [N_IN];
  logic      [N_OUT-1:0] out_valid;
  logic      [N_OUT-1:0] out_ready;
  logic      [N_OUT-1:0] xfer;
  logic      [N_OUT-1:0] sel;   // selected input per output, 0 is west.
  flit_t                 out_flit [N_OUT];

  assign in_valid     = {i_in_l.valid, i_in_w.valid};
  assign in_flit[0]   = i_in_w.flit;
  assign in_flit[1]   = i_in_l.flit;
  assign in_port[0]   = i_in_w.port;
  assign in_port[1]   = i_in_l.port;
  assign i_in_w.ready = in_ready[0];
  assign i_in_l.ready = in_ready[1];

  assign out_ready = {i_l_ready, i_n_ready, i_e_ready};

  for (genvar g = 0; g < N_OUT; g++) begin : g_out
    logic [N_IN-1:0] req;
    logic            lock_q;
    logic            owner_q;
    logic            last_q;

    assign req[0] = in_valid[0] && (in_port[0] == out_port_e'(g));
    assign req[1] = in_valid[1] && (in_port[1] == out_port_e'(g));

    // a free output goes to the input after the last winner.
    assign sel[g]       = lock_q ? owner_q : ((&req) ? !last_q : req[1]);
    assign out_valid[g] = lock_q ? req[owner_q] : (|req);
    assign out_flit[g]  = in_flit[sel[g]];
    assign xfer[g]      = out_valid[g] && out_ready[g];

    always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
        lock_q  <= 1'b0;
        owner_q <= 1'b0;
        last_q  <= 1'b1;
      end
      else if (i_clear) begin
        lock_q <= 1'b0;
      end
      else if (xfer[g]) begin
        if (!lock_q) begin
          last_q <= sel[g];
        end
        if (out_flit[g].kind == HEAD) begin
          lock_q  <= 1'b1;
          owner_q <= sel[g];
        end
        else if (out_flit[g].kind == TAIL) begin
          lock_q <= 1'b0;
        end
      end
    end
  end

  // an input routes to one output only, so at most one term is set per input.
  always_comb begin
    in_ready = '0;
    for (int o = 0; o < N_OUT; o++) begin
      if (xfer[o]) begin
        in_ready[sel[o]] = 1'b1;
      end
    end
  end

  assign o_e_valid = out_valid[PORT_EAST];
  assign o_e_flit  = out_flit[PORT_EAST];
  assign o_n_valid = out_valid[PORT_NORTH];
  assign o_n_flit  = out_flit[PORT_NORTH];
  assign o_l_valid = out_valid[PORT_LOCAL];
  assign o_l_flit  = out_flit[PORT_LOCAL];
endmodule

// File: source/noc_router.sv
`timescale 1ns/1ps
`include "noc_router_cfg.svh"

module noc_router
  import noc_pkg::*;
#(
  parameter logic [`NOC_COORD_BITS-1:0] MY_X = `NOC_COORD_BITS'(2),
  parameter logic [`NOC_COORD_BITS-1:0] MY_Y = `NOC_COORD_BITS'(2)
)(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  i_clear,
  input  logic  i_w_valid,
  output logic  o_w_ready,
  input  flit_t i_w_flit,
  output logic  o_w_almost_full,
  input  logic  i_l_valid,
  output logic  o_l_ready,
  input  flit_t i_l_flit,
  output logic  o_l_almost_full,
  output logic  o_e_valid,
  input  logic  i_e_ready,
  output flit_t o_e_flit,
  output logic  o_n_valid,
  input  logic  i_n_ready,
  output flit_t o_n_flit,
  output logic  o_l_valid,
  input  logic  i_l_ready,
  output flit_t o_l_flit
);
  noc_flit_if w_link ();
  noc_flit_if l_link ();

  noc_input_unit #(.MY_X(MY_X), .MY_Y(MY_Y)) u_in_w (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_clear       (i_clear),
    .i_valid       (i_w_valid),
    .o_ready       (o_w_ready),
    .i_flit        (i_w_flit),
    .o_almost_full (o_w_almost_full),
    .o_out         (w_link.sender)
  );

  noc_input_unit #(.MY_X(MY_X), .MY_Y(MY_Y)) u_in_l (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_clear       (i_clear),
    .i_valid       (i_l_valid),
    .o_ready       (o_l_ready),
    .i_flit        (i_l_flit),
    .o_almost_full (o_l_almost_full),
    .o_out         (l_link.sender)
  );

  noc_switch u_switch (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_clear   (i_clear),
    .i_in_w    (w_link.receiver),
    .i_in_l    (l_link.receiver),
    .o_e_valid (o_e_valid),
    .i_e_ready (i_e_ready),
    .o_e_flit  (o_e_flit),
    .o_n_valid (o_n_valid),
    .i_n_ready (i_n_ready),
    .o_n_flit  (o_n_flit),
    .o_l_valid (o_l_valid),
    .i_l_ready (i_l_ready),
    .o_l_flit  (o_l_flit)
  );
endmodule

// File: bench/noc_router_checker.sv
`timescale 1ns/1ps

module noc_router_checker
  import noc_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic [2:0] i_valid,
  input logic [2:0] i_ready,
  input flit_t      i_flit [3]
);
  flit_t exp_q [3][2][$];   // per output, per source.
  logic  open_q [3];
  int    open_src [3];
  int    errors;
  int    checked;
  int    delivered [2];
  string names [3];

  initial begin
    errors       = 0;
    checked      = 0;
    delivered[0] = 0;
    delivered[1] = 0;
    names[0]     = "o_e_flit";
    names[1]     = "o_n_flit";
    names[2]     = "o_l_flit";
    for (int o = 0; o < 3; o++) begin
      open_q[o]   = 1'b0;
      open_src[o] = 0;
    end
  end

  task automatic expect_flit(input int o, input int src, input flit_t f);
    exp_q[o][src].push_back(f);
  endtask

  task automatic flush_all();
    for (int o = 0; o < 3; o++) begin
      open_q[o] = 1'b0;
      for (int s = 0; s < 2; s++) begin
        exp_q[o][s].delete();
      end
    end
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int o = 0; o < 3; o++) begin
      for (int s = 0; s < 2; s++) begin
        n += exp_q[o][s].size();
      end
    end
    return n;
  endfunction

  task automatic check_flit(input int o, input flit_t f);
    int    src;
    flit_t exp;
    src = int'(f.payload[31]);   // source id rides in the top payload bit.
    checked++;
    delivered[src]++;
    if (open_q[o] && open_src[o] != src) begin
      $display("packet interleave on %s at time %0t, source %0d cut into source %0d",
               names[o], $time, src, open_src[o]);
      errors++;
    end
    if (exp_q[o][src].size() == 0) begin
      $display("unexpected flit %h on %s at time %0t", f, names[o], $time);
      errors++;
    end
    else begin
      exp = exp_q[o][src].pop_front();
      if (f !== exp) begin
        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                 $time, names[o], exp, f);
        errors++;
      end
    end
    if (f.kind == HEAD) begin
      open_q[o]   = 1'b1;
      open_src[o] = src;
    end
    else if (f.kind == TAIL) begin
      open_q[o] = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      for (int o = 0; o < 3; o++) begin
        if (i_valid[o] && i_ready[o]) begin
          check_flit(o, i_flit[o]);
        end
      end
    end
  end
endmodule

// File: bench/noc_router_tb.sv
`timescale 1ns/1ps
`include "noc_router_cfg.svh"

module noc_router_tb
  import noc_pkg::*;
();
  localparam logic [3:0] MY_X = 4'd2;
  localparam logic [3:0] MY_Y = 4'd2;
  localparam int CLK_PERIOD = 10;
  localparam int PKT_COUNT  = 33;
  localparam int CYC_WORST  = 20;
  localparam int DEPTH      = `NOC_BUF_DEPTH;
  localparam int THRESH     = `NOC_BUF_THRESHOLD;

  logic        clk;
  logic        rst_n;
  logic        clear;
  logic [1:0]  in_valid;
  flit_t       in_flit [2];
  wire  [1:0]  in_ready;
  wire  [1:0]  in_afull;
  wire  [2:0]  out_valid;
  logic [2:0]  out_ready;
  wire  flit_t out_flit [3];
  int          stall_mode [3];   // 0 ready, 1 stalled, 2 random.
  logic [31:0] stim_state;
  logic [31:0] bp_state;
  int          seq_num [2];
  int          accepted [2];
  int          tb_errors;
  int          test_start;
  logic        track_fill;
  logic        saw_full;

  noc_router #(.MY_X(MY_X), .MY_Y(MY_Y)) uut (
    .clk(clk), .rst_n(rst_n), .i_clear(clear),
    .i_w_valid(in_valid[0]), .o_w_ready(in_ready[0]), .i_w_flit(in_flit[0]),
    .o_w_almost_full(in_afull[0]),
    .i_l_valid(in_valid[1]), .o_l_ready(in_ready[1]), .i_l_flit(in_flit[1]),
    .o_l_almost_full(in_afull[1]),
    .o_e_valid(out_valid[0]), .i_e_ready(out_ready[0]), .o_e_flit(out_flit[0]),
    .o_n_valid(out_valid[1]), .i_n_ready(out_ready[1]), .o_n_flit(out_flit[1]),
    .o_l_valid(out_valid[2]), .i_l_ready(out_ready[2]), .o_l_flit(out_flit[2])
  );

  noc_router_checker chk (
    .clk(clk), .rst_n(rst_n), .i_valid(out_valid), .i_ready(out_ready), .i_flit(out_flit)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int rand_below(input int n);
    stim_state = lcg_next(stim_state);
    return int'(stim_state[30:16]) % n;
  endfunction

  // xy rule, 0 east, 1 north, 2 local.
  function automatic int expected_port(input logic [3:0] dx, input logic [3:0] dy);
    if (dx > MY_X) return 0;
    if (dy > MY_Y) return 1;
    return 2;
  endfunction

  task automatic report_value(input string sig, input int exp, input int act);
    $display("CHECK FAILED time=%0t signal=%s expected=%0d actual=%0d", $time, sig, exp, act);
    tb_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("problem at time %0t: %s", $time, msg);
    tb_errors++;
  endtask

  task automatic pick_dest(input int cls, output logic [3:0] dx, output logic [3:0] dy);
    if (cls < 0) cls = rand_below(3);
    dx = (cls == 0) ? 4'(3 + rand_below(13)) : MY_X;
    dy = (cls == 0) ? 4'(2 + rand_below(14)) : (cls == 1) ? 4'(3 + rand_below(13)) : MY_Y;
  endtask

  // occupancy predicted from accepted minus delivered flits.
  task automatic check_fill(input int src);
    int occ;
    occ = accepted[src] - chk.delivered[src];
    if (occ >= DEPTH) saw_full = 1'b1;
    if (in_ready[src] !== (occ < DEPTH)) begin
      report_value((src == 0) ? "o_w_ready" : "o_l_ready", occ < DEPTH, in_ready[src]);
    end
    if (in_afull[src] !== (occ >= THRESH)) begin
      report_value((src == 0) ? "o_w_almost_full" : "o_l_almost_full", occ >= THRESH,
                   in_afull[src]);
    end
  endtask

  task automatic send_flit(input int src, input flit_t f, input int port);
    logic done;
    done = 1'b0;
    @(negedge clk);
    in_valid[src] = 1'b1;
    in_flit[src]  = f;
    while (!done) begin
      if (track_fill && src == 0) check_fill(src);
      if (in_ready[src]) done = 1'b1;
      else @(negedge clk);
    end
    accepted[src]++;
    chk.expect_flit(port, src, f);   // accepted at the coming rising edge.
  endtask

  task automatic release_input(input int src);
    @(negedge clk);
    in_valid[src] = 1'b0;
  endtask

  task automatic send_packet(input int src, input int len, input logic [3:0] dx,
                             input logic [3:0] dy);
    flit_t f;
    for (int i = 0; i < len; i++) begin
      f.kind = (len == 1) ? SINGLE : (i == 0) ? HEAD : (i == len - 1) ? TAIL : BODY;
      if (f.kind == BODY || f.kind == TAIL) begin
        f.payload = {src[0], 31'(seq_num[src])};   // no destination in these.
      end
      else begin
        f.payload = {src[0], 23'(seq_num[src]), dy, dx};
      end
      seq_num[src]++;
      send_flit(src, f, expected_port(dx, dy));
    end
    release_input(src);
  endtask

  task automatic send_stream(input int src, input int count, input int cls, input int len);
    logic [3:0] dx;
    logic [3:0] dy;
    for (int p = 0; p < count; p++) begin
      pick_dest(cls, dx, dy);
      send_packet(src, (len > 0) ? len : 1 + rand_below(4), dx, dy);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (chk.pending() != 0 && cycles < 400) begin
      @(negedge clk);
      cycles++;
    end
    if (chk.pending() != 0) report_problem("expected flits never reached an output");
  endtask

  task automatic end_test(input string name);
    int now;
    now = tb_errors + chk.errors;
    $display("test %s: %0d errors", name, now - test_start);
    test_start = now;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    for (int o = 0; o < 3; o++) begin
      if (stall_mode[o] == 0) out_ready[o] = 1'b1;
      else if (stall_mode[o] == 1) out_ready[o] = 1'b0;
      else begin
        bp_state     = lcg_next(bp_state);
        out_ready[o] = bp_state[16];
      end
    end
  end

  initial begin
    #(PKT_COUNT * 4 * CYC_WORST * CLK_PERIOD + 1000 * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [3:0] dx;
    logic [3:0] dy;
    flit_t      lone_head;
    rst_n = 1'b0;
    clear = 1'b0;
    in_valid = 2'b00;
    in_flit[0] = '0;
    in_flit[1] = '0;
    out_ready = 3'b111;
    stim_state = 32'd60;
    bp_state = lcg_next(32'd60);
    tb_errors = 0;
    test_start = 0;
    track_fill = 1'b0;
    saw_full = 1'b0;
    for (int i = 0; i < 3; i++) stall_mode[i] = 0;
    for (int i = 0; i < 2; i++) begin
      seq_num[i] = 0;
      accepted[i] = 0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (out_valid !== 3'b000) report_value("out_valid", 0, out_valid);
    if (in_ready !== 2'b11) report_value("in_ready", 3, in_ready);
    if (in_afull !== 2'b00) report_value("in_afull", 0, in_afull);
    end_test("reset");

    for (int src = 0; src < 2; src++) begin
      for (int cls = 0; cls < 3; cls++) send_stream(src, 1, cls, 1);
    end
    wait_drain();
    end_test("routing");

    pick_dest(-1, dx, dy);
    send_packet(1, 1, dx, dy);
    if (out_valid[expected_port(dx, dy)] !== 1'b1) begin
      report_problem("first flit not offered on the cycle after its acceptance");
    end
    send_stream(1, 6, -1, 0);
    wait_drain();
    end_test("burst");

    stall_mode[1] = 2;
    fork
      send_stream(0, 4, 1, 0);
      send_stream(1, 4, 1, 0);
    join
    wait_drain();
    stall_mode[1] = 0;
    end_test("contention");

    stall_mode[0] = 1;
    track_fill = 1'b1;
    fork
      send_stream(0, 3, 0, 4);
      begin
        repeat (30) @(negedge clk);
        stall_mode[0] = 2;
      end
    join
    track_fill = 1'b0;
    wait_drain();
    stall_mode[0] = 0;
    if (!saw_full) report_problem("the west buffer never reached full");
    end_test("backpressure");

    // west packet left open on north so that clear has a held route and a grant to drop.
    pick_dest(1, dx, dy);
    lone_head.kind    = HEAD;
    lone_head.payload = {1'b0, 23'(seq_num[0]), dy, dx};
    seq_num[0]++;
    send_flit(0, lone_head, expected_port(dx, dy));
    release_input(0);
    wait_drain();
    for (int i = 0; i < 3; i++) stall_mode[i] = 1;
    fork
      send_stream(0, 2, 1, 4);
      send_stream(1, 2, 0, 4);
    join
    check_fill(0);
    check_fill(1);
    @(negedge clk);
    clear = 1'b1;
    chk.flush_all();
    @(negedge clk);
    clear = 1'b0;
    if (in_afull !== 2'b00) report_value("in_afull", 0, in_afull);
    if (in_ready !== 2'b11) report_value("in_ready", 3, in_ready);
    for (int i = 0; i < 3; i++) stall_mode[i] = 0;
    repeat (10) @(negedge clk);
    send_stream(0, 2, 0, 0);
    send_stream(1, 2, 1, 0);
    wait_drain();
    end_test("clear");

    repeat (5) @(negedge clk);
    $display("flits checked %0d, errors %0d", chk.checked, tb_errors + chk.errors);
    if (tb_errors + chk.errors == 0) begin
      $display("No errors");
    end
    else begin
      $display("Errors found");
    end
    $finish;
  end
endmodule

// File: noc_router.f
+incdir+source
source/noc_pkg.sv
source/noc_flit_if.sv
source/noc_fifo_mem.sv
source/noc_input_unit.sv
source/noc_switch.sv
source/noc_router.sv
bench/noc_router_checker.sv
bench/noc_router_tb.sv

// File: build.sh
#!/usr/bin/env bash
# Build the noc_router testbench with Verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal \
  -f noc_router.f \
  --top-module noc_router_tb \
  -Mdir "$OBJ" -o noc_router_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

"./$OBJ/noc_router_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi

if ! grep -q "No errors" "$LOG"; then
  echo "simulation ended without a verdict"
  exit 1
fi
exit 0
